// File: src/frontend_pkg.sv
package frontend_pkg;

    // datapath and address width
    localparam int XLEN = 32;

    // predictor table geometry
    localparam int PRED_ENTRIES = 32;
    localparam int PRED_IDX_W   = 5;                     // pc[5:1]
    localparam int TAG_W        = XLEN - PRED_IDX_W - 1; // pc[31:6]

    // reset values
    localparam logic [XLEN-1:0] RESET_PC      = 32'h0000_0000;
    localparam logic [XLEN-1:0] RESET_HANDLER = 32'h0000_0100;

    // pc increments
    localparam logic [XLEN-1:0] INSTR_LEN_FULL = 32'd4;
    localparam logic [XLEN-1:0] INSTR_LEN_COMP = 32'd2;

    // 2-bit saturating counter where msb set means taken
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'b00,
        WEAK_NOT_TAKEN   = 2'b01,
        WEAK_TAKEN       = 2'b10,
        STRONG_TAKEN     = 2'b11
    } pred_state_e;

    // configuration register map
    typedef enum logic {
        CFG_HANDLER = 1'b0, // exception handler address
        CFG_CONTROL = 1'b1  // bit 0 predictor enable
    } cfg_addr_e;

endpackage : frontend_pkg

// File: src/front_end_config.sv
`timescale 1ns/1ps

module front_end_config (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          cfg_we_i,
    input  logic                          cfg_addr_i,
    input  logic [frontend_pkg::XLEN-1:0] cfg_wdata_i,
    output logic [frontend_pkg::XLEN-1:0] cfg_rdata_o,
    output logic [frontend_pkg::XLEN-1:0] handler_pc_o,
    output logic                          pred_enable_o
);

    import frontend_pkg::*;

    logic [XLEN-1:0] handler_q;
    logic            pred_enable_q;
    cfg_addr_e       addr;

    assign addr = cfg_addr_e'(cfg_addr_i);

    always_ff @(posedge clk_i) begin : cfg_regs
        if (!rst_n_i) begin
            handler_q     <= RESET_HANDLER;
            pred_enable_q <= 1'b1;                 // predictor on out of reset
        end else if (cfg_we_i) begin
            case (addr)
                CFG_HANDLER: handler_q     <= cfg_wdata_i;
                CFG_CONTROL: pred_enable_q <= cfg_wdata_i[0];
                default: ;                         // unmapped address dropped
            endcase
        end
    end : cfg_regs

    // readback mux
    always_comb begin
        case (addr)
            CFG_HANDLER: cfg_rdata_o = handler_q;
            CFG_CONTROL: cfg_rdata_o = {{(XLEN-1){1'b0}}, pred_enable_q};
            default:     cfg_rdata_o = '0;
        endcase
    end

    assign handler_pc_o  = handler_q;
    assign pred_enable_o = pred_enable_q;

endmodule : front_end_config

// File: src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [frontend_pkg::XLEN-1:0] pc_i,
    input  logic                          pred_enable_i,
    input  logic                          executed_i,
    input  logic                          branch_i,
    input  logic                          jump_i,
    input  logic                          taken_i,
    input  logic [frontend_pkg::XLEN-1:0] instr_address_i,
    input  logic [frontend_pkg::XLEN-1:0] branch_target_addr_i,
    output logic                          predict_taken_o,
    output logic [frontend_pkg::XLEN-1:0] predict_target_o,
    output logic                          mispredicted_o
);

    import frontend_pkg::*;

    pred_state_e     counter_q    [PRED_ENTRIES];
    logic            btb_valid_q  [PRED_ENTRIES];
    logic [TAG_W-1:0] btb_tag_q   [PRED_ENTRIES];
    logic [XLEN-1:0] btb_target_q [PRED_ENTRIES];

    logic [PRED_IDX_W-1:0] fetch_idx, res_idx;
    logic [TAG_W-1:0]      fetch_tag, res_tag;
    logic                  fetch_hit, res_hit, res_predict, resolved;
    pred_state_e           res_counter, next_counter;

    // lookup for the pc being fetched
    assign fetch_idx = pc_i[PRED_IDX_W:1];
    assign fetch_tag = pc_i[XLEN-1:PRED_IDX_W+1];
    assign fetch_hit = btb_valid_q[fetch_idx] & (btb_tag_q[fetch_idx] == fetch_tag);

    assign predict_taken_o  = pred_enable_i & fetch_hit
                            & (counter_q[fetch_idx] inside {WEAK_TAKEN, STRONG_TAKEN});
    assign predict_target_o = btb_target_q[fetch_idx];

    // same lookup for the resolving instruction on the table before update
    assign res_idx     = instr_address_i[PRED_IDX_W:1];
    assign res_tag     = instr_address_i[XLEN-1:PRED_IDX_W+1];
    assign res_hit     = btb_valid_q[res_idx] & (btb_tag_q[res_idx] == res_tag);
    assign res_counter = counter_q[res_idx];
    assign res_predict = pred_enable_i & res_hit
                       & (res_counter inside {WEAK_TAKEN, STRONG_TAKEN});

    assign resolved = executed_i & (branch_i | jump_i);

    // wrong direction, or right direction with a stale target
    assign mispredicted_o = resolved & ((res_predict != taken_i)
                          | (res_predict & taken_i
                             & (btb_target_q[res_idx] != branch_target_addr_i)));

    always_comb begin
        next_counter = res_counter;
        if (jump_i) begin
            next_counter = STRONG_TAKEN;           // jumps always go
        end else if (taken_i) begin
            case (res_counter)
                STRONG_NOT_TAKEN: next_counter = WEAK_NOT_TAKEN;
                WEAK_NOT_TAKEN:   next_counter = WEAK_TAKEN;
                default:          next_counter = STRONG_TAKEN;
            endcase
        end else begin
            case (res_counter)
                STRONG_TAKEN: next_counter = WEAK_TAKEN;
                WEAK_TAKEN:   next_counter = WEAK_NOT_TAKEN;
                default:      next_counter = STRONG_NOT_TAKEN;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin : counter_table
        if (!rst_n_i) begin
            for (int i = 0; i < PRED_ENTRIES; i++) begin
                counter_q[i]   <= WEAK_NOT_TAKEN;
                btb_valid_q[i] <= 1'b0;
            end
        end else if (resolved) begin
            counter_q[res_idx] <= next_counter;
            if (taken_i) begin
                btb_valid_q[res_idx] <= 1'b1;
            end
        end
    end : counter_table

    // tag and target storage
    always_ff @(posedge clk_i) begin : btb_payload
        if (resolved & taken_i) begin
            btb_tag_q[res_idx]    <= res_tag;
            btb_target_q[res_idx] <= branch_target_addr_i;
        end
    end : btb_payload

endmodule : branch_predictor

// File: src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          fetch_wait_i,
    input  logic                          fetch_valid_i,
    input  logic                          compressed_i,
    input  logic                          exception_i,
    input  logic [frontend_pkg::XLEN-1:0] handler_pc_i,
    input  logic                          mispredicted_i,
    input  logic                          taken_i,
    input  logic                          res_compressed_i,
    input  logic [frontend_pkg::XLEN-1:0] instr_address_i,
    input  logic [frontend_pkg::XLEN-1:0] branch_target_addr_i,
    input  logic                          predict_taken_i,
    input  logic [frontend_pkg::XLEN-1:0] predict_target_i,
    output logic [frontend_pkg::XLEN-1:0] pc_o
);

    import frontend_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] seq_pc;       // fall-through of the fetched word
    logic [XLEN-1:0] recover_pc;   // fall-through of the resolved instr

    assign seq_pc     = pc_q + (compressed_i ? INSTR_LEN_COMP : INSTR_LEN_FULL);
    assign recover_pc = instr_address_i
                      + (res_compressed_i ? INSTR_LEN_COMP : INSTR_LEN_FULL);

    always_ff @(posedge clk_i) begin : pc_register
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!stall_i) begin
            if (exception_i) begin
                pc_q <= handler_pc_i;              // highest priority
            end else if (mispredicted_i) begin
                if (taken_i) begin
                    pc_q <= branch_target_addr_i;
                end else begin
                    pc_q <= recover_pc;
                end
            end else if (fetch_wait_i) begin
                pc_q <= pc_q;                      // memory busy
            end else if (fetch_valid_i) begin
                if (predict_taken_i) begin
                    pc_q <= predict_target_i;      // btb hit
                end else begin
                    pc_q <= seq_pc;
                end
            end
        end
    end : pc_register

    assign pc_o = pc_q;

endmodule : pc_gen

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          mispredicted_i,
    input  logic                          exception_i,
    input  logic                          fetch_wait_i,
    input  logic                          fetch_valid_i,
    input  logic [frontend_pkg::XLEN-1:0] fetch_instruction_i,
    input  logic [frontend_pkg::XLEN-1:0] pc_i,
    output logic                          fetch_o,
    output logic [frontend_pkg::XLEN-1:0] fetch_address_o,
    output logic                          compressed_o,
    output logic [frontend_pkg::XLEN-1:0] instr_o,
    output logic [frontend_pkg::XLEN-1:0] instr_pc_o,
    output logic                          instr_valid_o,
    output logic                          instr_compressed_o
);

    logic redirect;
    logic valid_q;

    assign redirect = flush_i | mispredicted_i | exception_i;

    // no request for a pc that is about to be replaced
    assign fetch_o         = !stall_i & !fetch_wait_i & !redirect;
    assign fetch_address_o = pc_i;

    // 32-bit encodings have both low bits set
    assign compressed_o = (fetch_instruction_i[1:0] != 2'b11);

    always_ff @(posedge clk_i) begin : stage_valid
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (redirect) begin
            valid_q <= 1'b0;                       // drop in-flight word
        end else if (!stall_i) begin
            valid_q <= fetch_valid_i;
        end
    end : stage_valid

    always_ff @(posedge clk_i) begin : stage_payload
        if (!stall_i && fetch_valid_i) begin
            instr_o            <= fetch_instruction_i;
            instr_pc_o         <= pc_i;
            instr_compressed_o <= compressed_o;
        end
    end : stage_payload

    assign instr_valid_o = valid_q;

endmodule : fetch_stage

// File: src/front_end.sv
`timescale 1ns/1ps

module front_end (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          exception_i,
    // instruction memory
    output logic                          fetch_o,
    output logic [frontend_pkg::XLEN-1:0] fetch_address_o,
    input  logic                          fetch_valid_i,
    input  logic                          fetch_wait_i,
    input  logic [frontend_pkg::XLEN-1:0] fetch_instruction_i,
    // resolution from execute
    input  logic                          executed_i,
    input  logic                          branch_i,
    input  logic                          jump_i,
    input  logic                          taken_i,
    input  logic                          compressed_i,
    input  logic [frontend_pkg::XLEN-1:0] instr_address_i,
    input  logic [frontend_pkg::XLEN-1:0] branch_target_addr_i,
    output logic                          mispredicted_o,
    // configuration
    input  logic                          cfg_we_i,
    input  logic                          cfg_addr_i,
    input  logic [frontend_pkg::XLEN-1:0] cfg_wdata_i,
    output logic [frontend_pkg::XLEN-1:0] cfg_rdata_o,
    // fetched instruction
    output logic [frontend_pkg::XLEN-1:0] instr_o,
    output logic [frontend_pkg::XLEN-1:0] instr_pc_o,
    output logic                          instr_valid_o,
    output logic                          instr_compressed_o
);

    import frontend_pkg::*;

    logic [XLEN-1:0] handler_pc, pc, predict_target;
    logic            pred_enable, predict_taken, fetch_compressed;

    front_end_config i_config (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .cfg_we_i      ( cfg_we_i    ),
        .cfg_addr_i    ( cfg_addr_i  ),
        .cfg_wdata_i   ( cfg_wdata_i ),
        .cfg_rdata_o   ( cfg_rdata_o ),
        .handler_pc_o  ( handler_pc  ),
        .pred_enable_o ( pred_enable )
    );

    branch_predictor i_predictor (
        .clk_i                ( clk_i                ),
        .rst_n_i              ( rst_n_i              ),
        .pc_i                 ( pc                   ),
        .pred_enable_i        ( pred_enable          ),
        .executed_i           ( executed_i           ),
        .branch_i             ( branch_i             ),
        .jump_i               ( jump_i               ),
        .taken_i              ( taken_i              ),
        .instr_address_i      ( instr_address_i      ),
        .branch_target_addr_i ( branch_target_addr_i ),
        .predict_taken_o      ( predict_taken        ),
        .predict_target_o     ( predict_target       ),
        .mispredicted_o       ( mispredicted_o       )
    );

    pc_gen i_pc_gen (
        .clk_i                ( clk_i                ),
        .rst_n_i              ( rst_n_i              ),
        .stall_i              ( stall_i              ),
        .fetch_wait_i         ( fetch_wait_i         ),
        .fetch_valid_i        ( fetch_valid_i        ),
        .compressed_i         ( fetch_compressed     ),
        .exception_i          ( exception_i          ),
        .handler_pc_i         ( handler_pc           ),
        .mispredicted_i       ( mispredicted_o       ),
        .taken_i              ( taken_i              ),
        .res_compressed_i     ( compressed_i         ),
        .instr_address_i      ( instr_address_i      ),
        .branch_target_addr_i ( branch_target_addr_i ),
        .predict_taken_i      ( predict_taken        ),
        .predict_target_i     ( predict_target       ),
        .pc_o                 ( pc                   )
    );

    fetch_stage i_fetch (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .stall_i             ( stall_i             ),
        .flush_i             ( flush_i             ),
        .mispredicted_i      ( mispredicted_o      ),
        .exception_i         ( exception_i         ),
        .fetch_wait_i        ( fetch_wait_i        ),
        .fetch_valid_i       ( fetch_valid_i       ),
        .fetch_instruction_i ( fetch_instruction_i ),
        .pc_i                ( pc                  ),
        .fetch_o             ( fetch_o             ),
        .fetch_address_o     ( fetch_address_o     ),
        .compressed_o        ( fetch_compressed    ),
        .instr_o             ( instr_o             ),
        .instr_pc_o          ( instr_pc_o          ),
        .instr_valid_o       ( instr_valid_o       ),
        .instr_compressed_o  ( instr_compressed_o  )
    );

endmodule : front_end

// File: tb/front_end_tb_stim.svh
// columns are op, address, data, taken, jump, exception after write,
// expected mispredict, expected fetch address afterwards and count
step_t steps [0:31];
int    num_steps = 0;

task automatic add_step(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                        input logic taken, input logic jump, input logic flag,
                        input logic exp_mis, input logic [31:0] exp_addr,
                        input logic [7:0] count);
    step_t s;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.taken    = taken;
    s.jump     = jump;
    s.flag     = flag;
    s.exp_mis  = exp_mis;
    s.exp_addr = exp_addr;
    s.count    = count;
    steps[num_steps] = s;
    num_steps++;
endtask

task automatic load_steps();
    add_step(OP_RUN_FETCH, 32'h0000_0000, 32'h0, 0, 0, 0, 0, 32'h0000_0018, 8);
    add_step(OP_CFG_WRITE, CFG_HANDLER, 32'h0000_0200, 0, 0, 1, 0, 32'h0000_0200, 0);
    add_step(OP_RUN_FETCH, 32'h0000_0200, 32'h0, 0, 0, 0, 0, 32'h0000_020a, 3);
    // counter starts weak_not_taken, so the first taken branch mispredicts
    add_step(OP_RESOLVE, 32'h0000_020c, 32'h0000_0300, 1, 0, 0, 1, 32'h0000_0300, 0);
    add_step(OP_RESOLVE, 32'h0000_020c, 32'h0000_0300, 1, 0, 0, 0, 32'h0000_0300, 0);
    add_step(OP_RUN_FETCH, 32'h0000_0300, 32'h0, 0, 0, 0, 0, 32'h0000_0308, 2);
    add_step(OP_CFG_WRITE, CFG_HANDLER, 32'h0000_0208, 0, 0, 1, 0, 32'h0000_0208, 0);
    add_step(OP_RUN_FETCH, 32'h0000_0208, 32'h0, 0, 0, 0, 0, 32'h0000_0300, 3); // btb hit
    // strong_taken drops to weak_taken and fetch falls through to 0x20c + 2
    add_step(OP_RESOLVE, 32'h0000_020c, 32'h0000_0300, 0, 0, 0, 1, 32'h0000_020e, 0);
    add_step(OP_RUN_FETCH, 32'h0000_020e, 32'h0, 0, 0, 0, 0, 32'h0000_0214, 2);
    add_step(OP_CFG_WRITE, CFG_CONTROL, 32'h0000_0000, 0, 0, 0, 0, 32'h0, 0);
    add_step(OP_CFG_WRITE, CFG_HANDLER, 32'h0000_020a, 0, 0, 1, 0, 32'h0000_020a, 0);
    add_step(OP_RUN_FETCH, 32'h0000_020a, 32'h0, 0, 0, 0, 0, 32'h0000_0210, 3);
    add_step(OP_STALL, 32'h0, 32'h0, 0, 0, 0, 0, 32'h0000_0210, 4);
    add_step(OP_WAIT_MEM, 32'h0, 32'h0, 0, 0, 0, 0, 32'h0000_0210, 5);
    add_step(OP_RUN_FETCH, 32'h0000_0210, 32'h0, 0, 0, 0, 0, 32'h0000_0218, 2);
endtask

// File: tb/front_end_tb.sv
`timescale 1ns/1ps

module front_end_tb;

    import frontend_pkg::*;

    typedef enum logic [2:0] {OP_CFG_WRITE, OP_RUN_FETCH, OP_RESOLVE, OP_STALL, OP_WAIT_MEM} op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;      // register, resolved pc or first fetched pc
        logic [31:0] data;      // register value or branch target
        logic        taken;
        logic        jump;
        logic        flag;      // pulse exception_i after a config write
        logic        exp_mis;
        logic [31:0] exp_addr;  // fetch address once the step is done
        logic [7:0]  count;     // instructions or cycles
    } step_t;

    localparam int FETCH_TIMEOUT = 40;

    logic            clk_i = 1'b0;
    logic            rst_n_i, stall_i, flush_i, exception_i, fetch_wait_i;
    logic            executed_i, branch_i, jump_i, taken_i, compressed_i, cfg_we_i, cfg_addr_i;
    logic [XLEN-1:0] instr_address_i, branch_target_addr_i, cfg_wdata_i;
    logic            fetch_valid_i = 1'b0;
    logic [XLEN-1:0] fetch_instruction_i = '0;
    logic            fetch_o, mispredicted_o, instr_valid_o, instr_compressed_o;
    logic [XLEN-1:0] fetch_address_o, cfg_rdata_o, instr_o, instr_pc_o;
    int              checks = 0;
    int              errors = 0;
    int              timeouts = 0;
    logic            mem_busy = 1'b0;
    int              mem_delay = 0;
    logic [XLEN-1:0] mem_addr = '0;

    `include "front_end_tb_stim.svh"

    always #4 clk_i = ~clk_i;

    front_end i_dut (.*);

    // odd multiplier spreads every address bit and the low bits encode the length
    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] mix;
        mix = (addr ^ 32'h5a3c_96e1) * 32'h0001_0193;
        word_at = {mix[31:2], addr[3] ? 2'b01 : 2'b11};
    endfunction

    // one request at a time that is dropped when the front end stalls or redirects
    always @(posedge clk_i) begin : memory_model
        fetch_valid_i <= 1'b0;
        if (stall_i || exception_i || flush_i || mispredicted_o) begin
            mem_busy <= 1'b0;
        end else if (mem_busy && !fetch_wait_i) begin
            if (mem_delay == 0) begin
                fetch_valid_i       <= 1'b1;
                fetch_instruction_i <= word_at(mem_addr);
                mem_busy            <= 1'b0;
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end else if (!mem_busy && fetch_o && !fetch_valid_i) begin
            mem_busy  <= 1'b1;
            mem_addr  <= fetch_address_o;
            mem_delay <= $urandom % 4;             // 0 to 3 extra cycles
        end
    end

    task automatic check_equal(input string name, input logic [XLEN-1:0] actual,
                               input logic [XLEN-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic wait_for_instr(output logic seen);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!instr_valid_o && cycles < FETCH_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        seen = instr_valid_o;
        if (!seen) begin
            timeouts++;
            $display("timeout: no instruction delivered within %0d cycles", FETCH_TIMEOUT);
        end
    endtask

    // returns on the edge after which the memory answer reaches the front end
    task automatic align_to_response();
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        stall_i <= 1'b0;
        @(negedge clk_i);
        while (!(mem_busy && mem_delay == 0) && cycles < FETCH_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!(mem_busy && mem_delay == 0)) begin
            timeouts++;
            $display("timeout: memory did not get ready to answer within %0d cycles",
                     FETCH_TIMEOUT);
        end
        @(posedge clk_i);
    endtask

    task automatic fetch_sequence(input step_t s);
        logic [XLEN-1:0] pc;
        logic            seen;
        pc = s.addr;
        @(posedge clk_i);
        stall_i <= 1'b0;
        for (int n = 0; n < s.count; n++) begin
            wait_for_instr(seen);
            if (!seen) break;
            check_equal("instr_pc_o", instr_pc_o, pc);
            check_equal("instr_o", instr_o, word_at(pc));
            check_equal("instr_compressed_o", instr_compressed_o, pc[3]);
            pc = pc + (pc[3] ? INSTR_LEN_COMP : INSTR_LEN_FULL);
            check_equal("fetch_address_o", fetch_address_o, (n == s.count - 1) ? s.exp_addr : pc);
        end
        @(posedge clk_i);
        stall_i <= 1'b1;
    endtask

    task automatic resolve_branch(input step_t s);
        if (s.exp_mis) begin
            align_to_response();                   // recovery meets a returning word
        end else begin
            @(posedge clk_i);
            stall_i <= 1'b0;
        end
        executed_i           <= 1'b1;
        branch_i             <= !s.jump;
        jump_i               <= s.jump;
        taken_i              <= s.taken;
        compressed_i         <= s.addr[3];
        instr_address_i      <= s.addr;
        branch_target_addr_i <= s.data;
        @(negedge clk_i);
        check_equal("mispredicted_o", mispredicted_o, s.exp_mis);
        @(posedge clk_i);
        stall_i    <= 1'b1;
        executed_i <= 1'b0;
        @(negedge clk_i);
        check_equal("fetch_address_o", fetch_address_o, s.exp_addr);
        check_equal("instr_valid_o", instr_valid_o, 1'b0);
    endtask

    task automatic write_config(input step_t s);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= s.addr[0];
        cfg_wdata_i <= s.data;
        @(posedge clk_i);
        cfg_we_i <= 1'b0;
        @(negedge clk_i);
        check_equal("cfg_rdata_o", cfg_rdata_o,
                    (s.addr[0] == CFG_CONTROL) ? {31'b0, s.data[0]} : s.data);
        if (s.flag) begin
            align_to_response();
            exception_i <= 1'b1;                   // lands with a returning word
            @(posedge clk_i);
            stall_i     <= 1'b1;
            exception_i <= 1'b0;
            @(negedge clk_i);
            check_equal("fetch_address_o", fetch_address_o, s.exp_addr);
            check_equal("instr_valid_o", instr_valid_o, 1'b0);
        end
    endtask

    task automatic hold_fetch(input step_t s);
        if (s.op == OP_WAIT_MEM) begin
            @(posedge clk_i);
            stall_i      <= 1'b0;                  // only memory holds the pc
            fetch_wait_i <= 1'b1;
        end else begin
            align_to_response();
            stall_i <= 1'b1;                       // stall lands on a returning word
        end
        repeat (s.count) begin
            @(negedge clk_i);
            check_equal("fetch_o", fetch_o, 1'b0);
            check_equal("fetch_address_o", fetch_address_o, s.exp_addr);
            check_equal("instr_valid_o", instr_valid_o, 1'b0);
        end
        @(posedge clk_i);
        stall_i      <= 1'b1;
        fetch_wait_i <= 1'b0;
        @(negedge clk_i);
        check_equal("fetch_address_o", fetch_address_o, s.exp_addr);
    endtask

    initial begin : stimulus
        step_t s;
        void'($urandom(32'h2217f957));
        rst_n_i              = 1'b0;
        stall_i              = 1'b1;               // front end idles between steps
        flush_i              = 1'b0;
        exception_i          = 1'b0;
        fetch_wait_i         = 1'b0;
        executed_i           = 1'b0;
        branch_i             = 1'b0;
        jump_i               = 1'b0;
        taken_i              = 1'b0;
        compressed_i         = 1'b0;
        instr_address_i      = '0;
        branch_target_addr_i = '0;
        cfg_we_i             = 1'b0;
        cfg_addr_i           = 1'b0;
        cfg_wdata_i          = '0;
        load_steps();
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_equal("fetch_address_o", fetch_address_o, RESET_PC);
        check_equal("fetch_o", fetch_o, 1'b0);
        check_equal("instr_valid_o", instr_valid_o, 1'b0);
        check_equal("mispredicted_o", mispredicted_o, 1'b0);
        for (int i = 0; i < num_steps; i++) begin
            s = steps[i];
            case (s.op)
                OP_CFG_WRITE: write_config(s);
                OP_RUN_FETCH: fetch_sequence(s);
                OP_RESOLVE:   resolve_branch(s);
                default:      hold_fetch(s);
            endcase
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : front_end_tb

// File: front_end.f
+incdir+tb
src/frontend_pkg.sv
src/front_end_config.sv
src/branch_predictor.sv
src/pc_gen.sv
src/fetch_stage.sv
src/front_end.sv
tb/front_end_tb.sv
